//--- led_settings.svh
`ifndef LED_SETTINGS_SVH
`define LED_SETTINGS_SVH

// Panel geometry
`define LED_NUM_DRIVERS 30
`define LED_PER_DRIVER 16
`define LED_FRAME_VOXELS 240
// Drivers below this index use the group-1 offset tables
`define LED_GROUP1_DRIVERS 20

// Poker mode depth and multiplexing
`define LED_POKER_SLOTS 9
`define LED_PAD_SLOTS 4
`define LED_COLUMNS 9

// APB register map
`define LED_APB_AW 8
`define LED_APB_DW 32
`define LED_REG_CTRL 'h0
`define LED_REG_PIX_ADDR 'h4
`define LED_REG_PIX_DATA 'h8
`define LED_REG_STATUS 'hC

`endif

//--- led_pkg.sv
`include "led_settings.svh"

package led_pkg;

    // RGB565 voxel, blue in the top bits
    typedef logic [15:0] voxel_t;
    typedef logic [$clog2(`LED_FRAME_VOXELS)-1:0] voxel_addr_t;
    typedef logic [$clog2(`LED_PER_DRIVER)-1:0] led_idx_t;
    typedef logic [$clog2(`LED_POKER_SLOTS)-1:0] slot_idx_t;
    typedef logic [1:0] color_idx_t;
    typedef logic [$clog2(`LED_COLUMNS)-1:0] column_idx_t;
    typedef logic [`LED_NUM_DRIVERS-1:0] driver_word_t;

    typedef struct packed {
        logic valid;
        logic bank;
        voxel_addr_t addr;
        voxel_t data;
    } fb_write_t;

    typedef struct packed {
        logic valid;
        led_idx_t led;
        slot_idx_t slot;
        color_idx_t color;
    } scan_pos_t;

    typedef enum logic [1:0] {st_idle, st_scanning, st_swap_wait} scan_state_t;

    // Voxel offset of each LED inside a driver's strip, by panel wiring
    localparam voxel_addr_t lut_rg_g0 [`LED_PER_DRIVER] = '{
        30, 35, 45, 40, 50, 55, 65, 60, 70, 75, 5, 0, 10, 15, 25, 20};
    localparam voxel_addr_t lut_b_g0 [`LED_PER_DRIVER] = '{
        40, 45, 70, 75, 60, 65, 10, 15, 0, 5, 30, 35, 20, 25, 50, 55};
    localparam voxel_addr_t lut_rg_g1 [`LED_PER_DRIVER] = '{
        10, 15, 25, 20, 30, 35, 45, 40, 50, 55, 65, 60, 70, 75, 5, 0};
    localparam voxel_addr_t lut_b_g1 [`LED_PER_DRIVER] = '{
        0, 5, 30, 35, 20, 25, 45, 55, 40, 50, 70, 75, 60, 65, 10, 15};

    // Two drivers share each of five strips, ten drivers per 80-voxel band
    function automatic voxel_addr_t driver_base(input int unsigned d);
        return voxel_addr_t'((d / 2) % 5 + 5 * `LED_PER_DRIVER * (d / 10));
    endfunction

    // Lowest voxel bit of a color
    function automatic logic [3:0] color_bit_base(input color_idx_t c);
        case (c)
            2'd0: return 4'd11;
            2'd1: return 4'd6;
            default: return 4'd0;
        endcase
    endfunction

endpackage

//--- apb_frame_port.sv
`timescale 1ns/1ps
`include "led_settings.svh"

module apb_frame_port (
    input  logic                   clk_33,
    input  logic                   nrst,
    input  logic [`LED_APB_AW-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`LED_APB_DW-1:0] pwdata,
    output logic [`LED_APB_DW-1:0] prdata,
    output logic                   pready,
    output led_pkg::fb_write_t     fb_wr,
    output logic                   scan_enable,
    output logic                   swap_request,
    input  logic                   swap_done,
    input  logic                   front_bank,
    input  logic [15:0]            slice_count
);
    import led_pkg::*;

    logic        wr_access;
    logic        wr_ctrl;
    logic        wr_pix_addr;
    logic        wr_pix_data;
    logic [1:0]  ctrl;
    voxel_addr_t pix_addr;
    voxel_addr_t pix_addr_next;

    // No wait states
    assign pready = 1'b1;

    assign wr_access = psel && penable && pwrite;
    assign wr_ctrl = wr_access && (paddr == `LED_REG_CTRL);
    assign wr_pix_addr = wr_access && (paddr == `LED_REG_PIX_ADDR);
    assign wr_pix_data = wr_access && (paddr == `LED_REG_PIX_DATA);

    assign pix_addr_next = (pix_addr == voxel_addr_t'(`LED_FRAME_VOXELS - 1)) ? '0
                                                                             : pix_addr + 1'b1;

    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            ctrl <= '0;
            pix_addr <= '0;
        end else begin
            // A host write wins over the swap acknowledge
            if (wr_ctrl) begin
                ctrl <= pwdata[1:0];
            end else if (swap_done) begin
                ctrl[1] <= 1'b0;
            end

            if (wr_pix_addr) begin
                pix_addr <= (pwdata < `LED_FRAME_VOXELS) ? voxel_addr_t'(pwdata) : '0;
            end else if (wr_pix_data) begin
                pix_addr <= pix_addr_next;
            end
        end
    end

    assign scan_enable = ctrl[0];
    assign swap_request = ctrl[1];

    // Pixels always land in the bank that is not on display
    assign fb_wr = '{valid: wr_pix_data, bank: !front_bank, addr: pix_addr,
                     data: voxel_t'(pwdata)};

    always_comb begin
        prdata = '0;
        case (paddr)
            `LED_REG_CTRL: prdata[1:0] = ctrl;
            `LED_REG_PIX_ADDR: prdata[$bits(voxel_addr_t)-1:0] = pix_addr;
            `LED_REG_STATUS: begin
                prdata[0] = front_bank;
                prdata[`LED_APB_DW-1 -: 16] = slice_count;
            end
            default: prdata = '0;
        endcase
    end

    // Access phase must follow a setup phase of the same transfer
    a_apb_setup: assert property (@(posedge clk_33) disable iff (!nrst)
        $rose(penable) |-> psel && $past(psel));

endmodule

//--- frame_store.sv
`timescale 1ns/1ps
`include "led_settings.svh"

module frame_store (
    input  logic                                       clk_33,
    input  led_pkg::fb_write_t                         fb_wr,
    input  logic                                       front_bank,
    input  led_pkg::voxel_addr_t [`LED_NUM_DRIVERS-1:0] rd_addr,
    output led_pkg::voxel_t [`LED_NUM_DRIVERS-1:0]      rd_voxel
);
    import led_pkg::*;

    // Two banks, one shown while the host fills the other
    voxel_t mem [2][`LED_FRAME_VOXELS];

    always_ff @(posedge clk_33) begin
        if (fb_wr.valid) begin
            mem[fb_wr.bank][fb_wr.addr] <= fb_wr.data;
        end
    end

    // One read port per driver, all into the front bank
    always_comb begin
        for (int d = 0; d < `LED_NUM_DRIVERS; d++) begin
            rd_voxel[d] = mem[front_bank][rd_addr[d]];
        end
    end

    // Writes stay inside the bank
    a_write_in_range: assert property (@(posedge clk_33)
        fb_wr.valid |-> (fb_wr.addr < `LED_FRAME_VOXELS));

endmodule

//--- bitplane_scanner.sv
`timescale 1ns/1ps
`include "led_settings.svh"

module bitplane_scanner (
    input  logic                                        clk_33,
    input  logic                                        nrst,
    input  logic                                        driver_ready,
    input  logic                                        scan_enable,
    input  logic                                        swap_request,
    output led_pkg::scan_pos_t                          pos,
    output led_pkg::voxel_addr_t [`LED_NUM_DRIVERS-1:0] rd_addr,
    output logic                                        front_bank,
    output logic                                        swap_done,
    output led_pkg::column_idx_t                        column,
    output logic [15:0]                                 slice_count
);
    import led_pkg::*;

    scan_state_t state;
    color_idx_t  color;
    led_idx_t    led;
    slot_idx_t   slot;
    logic        adv;
    logic        last_color;
    logic        last_led;
    logic        last_slot;
    logic        last_column;
    logic        slice_wrap;

    assign adv = driver_ready && scan_enable;
    assign last_color = (color == 2'd2);
    assign last_led = (led == '0);
    assign last_slot = (slot == '0);
    assign last_column = (column == column_idx_t'(`LED_COLUMNS - 1));
    assign slice_wrap = adv && last_color && last_led && last_slot && last_column;

    // Swap only once the request has been seen before the boundary
    assign swap_done = slice_wrap && swap_request && (state == st_swap_wait);

    // Color fastest, then LED downward, then bit slot MSB first, then column
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            color <= '0;
            led <= led_idx_t'(`LED_PER_DRIVER - 1);
            slot <= slot_idx_t'(`LED_POKER_SLOTS - 1);
            column <= '0;
        end else if (adv) begin
            if (!last_color) begin
                color <= color + 1'b1;
            end else begin
                color <= '0;
                if (!last_led) begin
                    led <= led - 1'b1;
                end else begin
                    led <= led_idx_t'(`LED_PER_DRIVER - 1);
                    if (!last_slot) begin
                        slot <= slot - 1'b1;
                    end else begin
                        slot <= slot_idx_t'(`LED_POKER_SLOTS - 1);
                        column <= last_column ? '0 : column + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            state <= st_idle;
            front_bank <= 1'b0;
            slice_count <= '0;
        end else begin
            if (slice_wrap) begin
                slice_count <= slice_count + 1'b1;
            end
            if (swap_done) begin
                front_bank <= !front_bank;
            end
            case (state)
                st_idle: begin
                    if (scan_enable) begin
                        state <= swap_request ? st_swap_wait : st_scanning;
                    end
                end
                st_scanning: begin
                    if (!scan_enable) begin
                        state <= st_idle;
                    end else if (swap_request) begin
                        state <= st_swap_wait;
                    end
                end
                st_swap_wait: begin
                    // A cleared request cancels the pending swap
                    if (!scan_enable) begin
                        state <= st_idle;
                    end else if (swap_done || !swap_request) begin
                        state <= st_scanning;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign pos = '{valid: adv, led: led, slot: slot, color: color};

    // Blue has its own wiring table, red and green share one
    always_comb begin
        voxel_addr_t offset;
        for (int d = 0; d < `LED_NUM_DRIVERS; d++) begin
            if (d < `LED_GROUP1_DRIVERS) begin
                offset = (color == 2'd0) ? lut_b_g1[led] : lut_rg_g1[led];
            end else begin
                offset = (color == 2'd0) ? lut_b_g0[led] : lut_rg_g0[led];
            end
            rd_addr[d] = driver_base(d) + offset;
        end
    end

    a_slot_range: assert property (@(posedge clk_33) disable iff (!nrst)
        slot <= slot_idx_t'(`LED_POKER_SLOTS - 1));

endmodule

//--- driver_word_out.sv
`timescale 1ns/1ps
`include "led_settings.svh"

module driver_word_out (
    input  logic                                   clk_33,
    input  logic                                   nrst,
    input  led_pkg::scan_pos_t                     pos,
    input  led_pkg::column_idx_t                   column,
    input  led_pkg::voxel_t [`LED_NUM_DRIVERS-1:0] rd_voxel,
    output led_pkg::driver_word_t                  data,
    output logic                                   slice_start
);
    import led_pkg::*;

    logic [3:0]   bit_sel;
    logic         slot_sent;
    logic         first_pos;
    driver_word_t word_next;

    // Slots 8 to 4 carry the top five bits of the color
    assign slot_sent = (pos.slot >= slot_idx_t'(`LED_PAD_SLOTS));
    assign bit_sel = 4'(pos.slot - slot_idx_t'(`LED_PAD_SLOTS)) + color_bit_base(pos.color);

    always_comb begin
        for (int d = 0; d < `LED_NUM_DRIVERS; d++) begin
            word_next[d] = pos.valid && slot_sent && rd_voxel[d][bit_sel];
        end
    end

    // Blue of the top LED, MSB slot, first column
    assign first_pos = pos.valid
                    && (pos.color == '0)
                    && (pos.led == led_idx_t'(`LED_PER_DRIVER - 1))
                    && (pos.slot == slot_idx_t'(`LED_POKER_SLOTS - 1))
                    && (column == '0);

    // Cycles without an advance leave a zero word behind
    always_ff @(posedge clk_33 or negedge nrst) begin
        if (!nrst) begin
            data <= '0;
            slice_start <= 1'b0;
        end else begin
            data <= word_next;
            slice_start <= first_pos;
        end
    end

endmodule

//--- led_frame_top.sv
`timescale 1ns/1ps
`include "led_settings.svh"

module led_frame_top (
    input  logic                   clk_33,
    input  logic                   nrst,
    input  logic [`LED_APB_AW-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`LED_APB_DW-1:0] pwdata,
    output logic [`LED_APB_DW-1:0] prdata,
    output logic                   pready,
    input  logic                   driver_ready,
    output led_pkg::driver_word_t  data,
    output led_pkg::column_idx_t   column,
    output logic                   slice_start
);
    import led_pkg::*;

    fb_write_t   fb_wr;
    logic        scan_enable;
    logic        swap_request;
    logic        swap_done;
    logic        front_bank;
    logic [15:0] slice_count;
    scan_pos_t   pos;
    voxel_addr_t [`LED_NUM_DRIVERS-1:0] rd_addr;
    voxel_t      [`LED_NUM_DRIVERS-1:0] rd_voxel;

    apb_frame_port apb_i (
        .clk_33, .nrst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .fb_wr, .scan_enable, .swap_request, .swap_done, .front_bank, .slice_count
    );

    frame_store store_i (.clk_33, .fb_wr, .front_bank, .rd_addr, .rd_voxel);

    bitplane_scanner scanner_i (
        .clk_33, .nrst, .driver_ready, .scan_enable, .swap_request,
        .pos, .rd_addr, .front_bank, .swap_done, .column, .slice_count
    );

    // Word for the scanner position of the previous cycle
    driver_word_out out_i (.clk_33, .nrst, .pos, .column, .rd_voxel, .data, .slice_start);

endmodule

//--- tb_led_frame.sv
`timescale 1ns/1ps
`include "led_settings.svh"

module tb_led_frame;
    import led_pkg::*;

    localparam int PERIOD = 8;
    localparam int SLICE_ADV = `LED_COLUMNS * `LED_POKER_SLOTS * `LED_PER_DRIVER * 3;
    localparam int BP_CYCLES = 1000;
    localparam int LOAD_CYCLES = 3 * (`LED_FRAME_VOXELS + 4);
    // Three slices of scanning, one back-pressure run, two frame loads, plus margin
    localparam int RUN_CYCLES = (16 + 3 * SLICE_ADV + BP_CYCLES + 2 * LOAD_CYCLES + 400) * 5 / 4;

    logic clk_33;
    logic nrst;
    logic [`LED_APB_AW-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`LED_APB_DW-1:0] pwdata;
    logic [`LED_APB_DW-1:0] prdata;
    logic pready;
    logic driver_ready;
    driver_word_t data;
    column_idx_t column;
    logic slice_start;

    int checks;
    int value_errors;
    int other_errors;
    logic [31:0] lfsr;
    voxel_t frame [2][`LED_FRAME_VOXELS];
    // Reference scan position and bank
    int model_color;
    int model_led;
    int model_slot;
    int model_col;
    int model_front;
    bit swap_pending;
    bit prev_ready;
    bit synced;

    led_frame_top dut_i (
        .clk_33, .nrst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .driver_ready, .data, .column, .slice_start
    );

    always #(PERIOD / 2) clk_33 = ~clk_33;

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        @(negedge clk_33);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk_33);
        penable = 1'b1;
        @(negedge clk_33);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
        @(negedge clk_33);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk_33);
        penable = 1'b1;
        // prdata settles during the access phase
        #(PERIOD / 4);
        rdata = prdata;
        check_value("APB pready", 1, pready);
        @(negedge clk_33);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // Expected word from the addressing and slot rules
    function automatic driver_word_t model_word();
        driver_word_t w;
        voxel_t v;
        int base;
        int off;
        int bit_base;
        w = '0;
        bit_base = (model_color == 0) ? 11 : (model_color == 1) ? 6 : 0;
        if (model_slot >= `LED_PAD_SLOTS) begin
            for (int d = 0; d < `LED_NUM_DRIVERS; d++) begin
                base = (d / 2) % 5 + 80 * (d / 10);
                if (d < 20) begin
                    off = (model_color == 0) ? lut_b_g1[model_led] : lut_rg_g1[model_led];
                end else begin
                    off = (model_color == 0) ? lut_b_g0[model_led] : lut_rg_g0[model_led];
                end
                v = frame[model_front][base + off];
                w[d] = v[model_slot - `LED_PAD_SLOTS + bit_base];
            end
        end
        return w;
    endfunction

    function automatic int model_index();
        return (((model_col * `LED_POKER_SLOTS) + (`LED_POKER_SLOTS - 1 - model_slot))
                * `LED_PER_DRIVER + (`LED_PER_DRIVER - 1 - model_led)) * 3 + model_color;
    endfunction

    task automatic model_start();
        model_color = 0;
        model_led = `LED_PER_DRIVER - 1;
        model_slot = `LED_POKER_SLOTS - 1;
        model_col = 0;
    endtask

    // Color, then LED down, then slot down, then column up
    task automatic model_advance();
        model_color++;
        if (model_color == 3) begin
            model_color = 0;
            model_led--;
            if (model_led < 0) begin
                model_led = `LED_PER_DRIVER - 1;
                model_slot--;
                if (model_slot < 0) begin
                    model_slot = `LED_POKER_SLOTS - 1;
                    model_col++;
                    if (model_col == `LED_COLUMNS) begin
                        model_col = 0;
                        if (swap_pending) begin
                            model_front = 1 - model_front;
                            swap_pending = 1'b0;
                        end
                    end
                end
            end
        end
    endtask

    // Mode 0 holds driver_ready low, 1 high, 2 random
    task automatic stream_check(input string name, input int n, input int mode);
        driver_word_t exp_word;
        logic exp_start;
        for (int i = 0; i < n; i++) begin
            exp_word = '0;
            exp_start = 1'b0;
            if (prev_ready) begin
                exp_word = model_word();
                exp_start = (model_index() == 0);
                model_advance();
            end
            check_value({name, " data"}, exp_word, data);
            check_value({name, " slice_start"}, exp_start, slice_start);
            // The column output follows the live scan position
            check_value({name, " column"}, model_col, column);
            case (mode)
                0: driver_ready = 1'b0;
                1: driver_ready = 1'b1;
                default: driver_ready = lfsr_bits(1);
            endcase
            prev_ready = driver_ready;
            @(negedge clk_33);
        end
    endtask

    task automatic wait_slice_start(input string name, input int max_cycles, output bit found);
        found = 1'b0;
        for (int i = 0; i < max_cycles && !found; i++) begin
            @(negedge clk_33);
            found = (slice_start === 1'b1);
        end
        assert (found) else begin
            $display("%s: no slice_start pulse within %0d cycles", name, max_cycles);
            other_errors++;
        end
    endtask

    task automatic load_frame(input int bank);
        voxel_t v;
        apb_write(`LED_REG_PIX_ADDR, 0);
        for (int i = 0; i < `LED_FRAME_VOXELS; i++) begin
            v = lfsr_bits(16);
            frame[bank][i] = v;
            apb_write(`LED_REG_PIX_DATA, v);
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] r;
        check_value("reset data", 0, data);
        check_value("reset slice_start", 0, slice_start);
        check_value("reset column", 0, column);
        apb_read(`LED_REG_CTRL, r);
        check_value("reset CTRL", 0, r);
        apb_read(`LED_REG_STATUS, r);
        check_value("reset STATUS", 0, r);
        apb_read(`LED_REG_PIX_ADDR, r);
        check_value("reset PIX_ADDR", 0, r);
    endtask

    task automatic test_registers();
        logic [31:0] r;
        int addr;
        apb_write(`LED_REG_CTRL, 2);
        apb_read(`LED_REG_CTRL, r);
        check_value("CTRL readback", 2, r);
        apb_write(`LED_REG_CTRL, 0);
        apb_read(`LED_REG_CTRL, r);
        check_value("CTRL readback", 0, r);
        addr = `LED_FRAME_VOXELS - 3;
        apb_write(`LED_REG_PIX_ADDR, addr);
        for (int k = 0; k < 4; k++) begin
            apb_write(`LED_REG_PIX_DATA, 16'h1234 + k);
            addr = (addr + 1) % `LED_FRAME_VOXELS;
            apb_read(`LED_REG_PIX_ADDR, r);
            check_value("PIX_ADDR increment", addr, r);
        end
    endtask

    task automatic test_output_stream();
        logic [31:0] r;
        bit found;
        load_frame(1);
        driver_ready = 1'b1;
        apb_write(`LED_REG_CTRL, 3);
        // First slice shows the unloaded bank, the swap lands at its end
        wait_slice_start("output stream", 64, found);
        if (found) begin
            wait_slice_start("output stream", SLICE_ADV + 16, found);
        end
        if (found) begin
            synced = 1'b1;
            model_front = 1;
            swap_pending = 1'b0;
            model_start();
            prev_ready = 1'b1;
            stream_check("output stream", SLICE_ADV, 1);
            stream_check("output stream", 1, 0);
            apb_read(`LED_REG_STATUS, r);
            check_value("output stream front bank", 1, r[0]);
            apb_read(`LED_REG_CTRL, r);
            check_value("output stream CTRL", 1, r);
        end
    endtask

    task automatic test_back_pressure();
        stream_check("back-pressure", BP_CYCLES, 2);
        stream_check("back-pressure", 1, 0);
    endtask

    task automatic test_double_buffer();
        logic [31:0] r0;
        logic [31:0] r1;
        // Scanner is parked, so the model position survives the load
        load_frame(1 - model_front);
        stream_check("double buffer", 300, 1);
        stream_check("double buffer", 1, 0);
        apb_read(`LED_REG_STATUS, r0);
        check_value("double buffer bank before swap", model_front, r0[0]);
        apb_write(`LED_REG_CTRL, 3);
        swap_pending = 1'b1;
        stream_check("double buffer", SLICE_ADV - model_index() + 300, 1);
        stream_check("double buffer", 1, 0);
        apb_read(`LED_REG_STATUS, r1);
        check_value("double buffer bank after swap", model_front, r1[0]);
        check_value("double buffer slice_count", r0[31:16] + 16'd1, r1[31:16]);
        apb_read(`LED_REG_CTRL, r1);
        check_value("double buffer CTRL", 1, r1);
    endtask

    initial begin
        clk_33 = 1'b0;
        nrst = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        driver_ready = 1'b0;
        lfsr = 32'h3a5f_02dd;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        prev_ready = 1'b0;
        synced = 1'b0;
        repeat (16) @(negedge clk_33);
        nrst = 1'b1;
        test_reset_state();
        test_registers();
        test_output_stream();
        if (synced) begin
            test_back_pressure();
            test_double_buffer();
        end
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(RUN_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", RUN_CYCLES);
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors + 1);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
led_pkg.sv
apb_frame_port.sv
frame_store.sv
bitplane_scanner.sv
driver_word_out.sv
led_frame_top.sv
tb_led_frame.sv

//--- Bender.yml
package:
  name: led_frame

export_include_dirs:
  - .

sources:
  - led_pkg.sv
  - apb_frame_port.sv
  - frame_store.sv
  - bitplane_scanner.sv
  - driver_word_out.sv
  - led_frame_top.sv
  - target: test
    files:
      - tb_led_frame.sv
